// File: Makefile
TOP = fp_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f files.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: files.f
logic/fp_format_pkg.sv
logic/fp_op_pkg.sv
logic/fp_operands_if.sv
logic/fp_raw_if.sv
logic/fp_req_ctrl.sv
logic/fp_unpack.sv
logic/fp_add_core.sv
logic/fp_mul_core.sv
logic/fp_norm_pack.sv
logic/fp_unit.sv
sim/fp_unit_tb.sv

// File: logic/fp_add_core.sv
module fp_add_core import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w
)
(
    input  logic          clk,
    input  logic          rst,
    fp_operands_if.sink   ops,
    fp_raw_if.source      raw
);

    localparam int sig_w = frac_w + 1;
    localparam int sum_w = 2 * sig_w + 1;  // carry bit plus sig_w guard bits
    localparam logic [exp_w-1:0] far_limit = exp_w'(frac_w + 1);

    logic              take;
    logic              a_larger;
    logic              eff_sub;
    logic              far_apart;
    logic              big_sign;
    logic [exp_w-1:0]  big_exp;
    logic [exp_w-1:0]  small_exp;
    logic [exp_w-1:0]  exp_diff;
    logic [sig_w-1:0]  big_sig;
    logic [sig_w-1:0]  small_sig;
    logic [sum_w-1:0]  big_ext;
    logic [sum_w-1:0]  small_ext;
    logic [sum_w-1:0]  sum;

    assign take = ops.valid && (ops.op == op_add);

    always_comb
    begin
        // larger magnitude: exponent first, then significand
        a_larger = (ops.exp_a > ops.exp_b) ||
                   ((ops.exp_a == ops.exp_b) && (ops.sig_a >= ops.sig_b));
        if (a_larger)
        begin
            big_sign  = ops.sign_a;
            big_exp   = ops.exp_a;
            big_sig   = ops.sig_a;
            small_exp = ops.exp_b;
            small_sig = ops.sig_b;
        end
        else
        begin
            big_sign  = ops.sign_b;
            big_exp   = ops.exp_b;
            big_sig   = ops.sig_b;
            small_exp = ops.exp_a;
            small_sig = ops.sig_a;
        end
        exp_diff  = big_exp - small_exp;
        far_apart = exp_diff > far_limit;  // larger operand passes through
        eff_sub   = ops.sign_a ^ ops.sign_b;

        // guard bits keep the aligned operand exact up to the limit
        big_ext   = {1'b0, big_sig, {sig_w{1'b0}}};
        small_ext = far_apart ? '0 : ({1'b0, small_sig, {sig_w{1'b0}}} >> exp_diff);
        sum       = eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            raw.valid <= 1'b0;
        else
            raw.valid <= take;
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            raw.sign       <= big_sign;
            raw.exp        <= {2'b00, big_exp};
            raw.sig        <= sum[sum_w-1:1];  // drop lowest guard bit
            raw.exact_zero <= (sum == '0);     // only on full cancellation
        end
    end

endmodule

// File: logic/fp_format_pkg.sv
package fp_format_pkg;

    // binary32 field layout, sign bit on top
    // [31]    sign
    // [30:23] biased exponent
    // [22:0]  stored fraction, hidden one implied

    localparam int sp_exp_w  = 8;   // exponent field width
    localparam int sp_frac_w = 23;  // stored fraction width

    // binary64 uses the same layout with exp_w 11 and frac_w 52.
    // Operand width and bias are derived per module from exp_w and frac_w.

endpackage

// File: logic/fp_mul_core.sv
module fp_mul_core import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w
)
(
    input  logic          clk,
    input  logic          rst,
    fp_operands_if.sink   ops,
    fp_raw_if.source      raw
);

    localparam logic signed [exp_w+1:0] bias = (exp_w + 2)'((1 << (exp_w - 1)) - 1);

    logic                     take;
    logic                     prod_sign;
    logic signed [exp_w+1:0]  exp_sum;
    logic [2*frac_w+1:0]      product;

    assign take = ops.valid && (ops.op == op_mul);

    assign prod_sign = ops.sign_a ^ ops.sign_b;

    // two extra bits hold results past either end of the range
    assign exp_sum = $signed({2'b00, ops.exp_a}) + $signed({2'b00, ops.exp_b}) - bias;

    // 1.f * 1.f lands in [1,4), full width so nothing is lost before truncation
    assign product = ops.sig_a * ops.sig_b;

    always_ff @(posedge clk)
    begin
        if (rst)
            raw.valid <= 1'b0;
        else
            raw.valid <= take;
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            raw.sign       <= prod_sign;
            raw.exp        <= exp_sum;
            raw.sig        <= product;
            raw.exact_zero <= 1'b0;  // normal inputs never give zero
        end
    end

endmodule

// File: logic/fp_norm_pack.sv
module fp_norm_pack import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w,
    localparam int op_w  = 1 + exp_w + frac_w
)
(
    input  logic            clk,
    input  logic            rst,
    fp_raw_if.sink          add_raw,
    fp_raw_if.sink          mul_raw,
    output logic [op_w-1:0] result,
    output fp_status_t      status,
    output logic            done
);

    localparam int raw_w = 2 * frac_w + 2;
    localparam logic signed [exp_w+1:0] max_code = (exp_w + 2)'((1 << exp_w) - 2);
    localparam logic signed [exp_w+1:0] min_code = (exp_w + 2)'(1);

    logic                     any_valid;
    logic                     sel_sign;
    logic                     sel_zero;
    logic signed [exp_w+1:0]  sel_exp;
    logic [raw_w-1:0]         sel_sig;
    logic                     found;
    logic [exp_w+1:0]         lead_zeros;
    logic [raw_w-1:0]         norm_sig;
    logic signed [exp_w+1:0]  norm_exp;
    logic [op_w-1:0]          next_result;
    fp_status_t               next_status;

    assign any_valid = add_raw.valid | mul_raw.valid;

    // only one core is valid per transaction
    assign sel_sign = add_raw.valid ? add_raw.sign       : mul_raw.sign;
    assign sel_zero = add_raw.valid ? add_raw.exact_zero : mul_raw.exact_zero;
    assign sel_exp  = add_raw.valid ? add_raw.exp        : mul_raw.exp;
    assign sel_sig  = add_raw.valid ? add_raw.sig        : mul_raw.sig;

    always_comb
    begin
        found      = 1'b0;
        lead_zeros = '0;
        for (int i = raw_w - 1; i >= 0; i--)
        begin
            if (!found)
            begin
                if (sel_sig[i])
                    found = 1'b1;
                else
                    lead_zeros = lead_zeros + 1'b1;
            end
        end
        // leading one moved to the top bit, hidden one sits one below the point
        norm_sig = sel_sig << lead_zeros;
        norm_exp = sel_exp + (exp_w + 2)'(1) - $signed(lead_zeros);

        next_status = '0;
        if (sel_zero)
            next_result = '0;  // +0 on cancellation
        else if (norm_exp > max_code)
        begin
            next_result = {sel_sign, max_code[exp_w-1:0], {frac_w{1'b1}}};
            next_status.overflow = 1'b1;
        end
        else if (norm_exp < min_code)
        begin
            next_result = {sel_sign, {(op_w - 1){1'b0}}};
            next_status.underflow = 1'b1;
        end
        else
            next_result = {sel_sign, norm_exp[exp_w-1:0], norm_sig[raw_w-2 -: frac_w]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result <= '0;
            status <= '0;
            done   <= 1'b0;
        end
        else
        begin
            done <= any_valid;
            if (any_valid)
            begin
                result <= next_result;  // held until the next operation
                status <= next_status;
            end
        end
    end

endmodule

// File: logic/fp_op_pkg.sv
package fp_op_pkg;

    // operation selected by the requester
    typedef enum logic
    {
        op_add = 1'b0,
        op_mul = 1'b1
    } fp_op_t;

    // result range flags, returned with every result
    typedef struct packed
    {
        logic overflow;   // saturated to largest finite
        logic underflow;  // flushed to signed zero
    } fp_status_t;

endpackage

// File: logic/fp_operands_if.sv
interface fp_operands_if import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w
)
();

    logic              sign_a;
    logic              sign_b;
    logic [exp_w-1:0]  exp_a;   // biased exponent
    logic [exp_w-1:0]  exp_b;
    logic [frac_w:0]   sig_a;   // hidden one on top
    logic [frac_w:0]   sig_b;
    fp_op_t            op;
    logic              valid;

    modport source
    (
        output sign_a, sign_b, exp_a, exp_b, sig_a, sig_b, op, valid
    );

    modport sink
    (
        input sign_a, sign_b, exp_a, exp_b, sig_a, sig_b, op, valid
    );

endinterface

// File: logic/fp_raw_if.sv
interface fp_raw_if import fp_format_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w
)
();

    // value = sig / 2**(2*frac_w) * 2**(exp - bias), two integer bits in sig
    logic                      sign;
    logic signed [exp_w+1:0]   exp;        // biased, room for out of range values
    logic [2*frac_w+1:0]       sig;
    logic                      exact_zero; // cancellation, packs as +0
    logic                      valid;

    modport source
    (
        output sign, exp, sig, exact_zero, valid
    );

    modport sink
    (
        input sign, exp, sig, exact_zero, valid
    );

endinterface

// File: logic/fp_req_ctrl.sv
module fp_req_ctrl import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w,
    localparam int op_w  = 1 + exp_w + frac_w
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  fp_op_t          op,
    input  logic [op_w-1:0] x,
    input  logic [op_w-1:0] y,
    input  logic            done,
    output logic            ack,
    output logic            start,
    output fp_op_t          op_q,
    output logic [op_w-1:0] x_q,
    output logic [op_w-1:0] y_q
);

    typedef enum logic [1:0]
    {
        st_waiting,
        st_busy,
        st_acknowledging,
        st_releasing
    } state_t;

    state_t state;
    logic   accept;

    assign accept = (state == st_waiting) && req;  // ack is always low here

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_waiting;
            ack   <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            start <= accept;  // one cycle launch
            case (state)
                st_waiting:
                    if (req)
                        state <= st_busy;
                st_busy:
                    if (done)
                    begin
                        ack   <= 1'b1;
                        state <= st_acknowledging;
                    end
                st_acknowledging:
                    if (!req)
                        state <= st_releasing;  // requester let go
                st_releasing:
                begin
                    ack   <= 1'b0;
                    state <= st_waiting;
                end
                default:
                    state <= st_waiting;
            endcase
        end
    end

    // operands held for the whole transaction
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q <= op;
            x_q  <= x;
            y_q  <= y;
        end
    end

endmodule

// File: logic/fp_unit.sv
module fp_unit import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w,
    localparam int op_w  = 1 + exp_w + frac_w
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  fp_op_t          op,
    input  logic [op_w-1:0] x,
    input  logic [op_w-1:0] y,
    output logic            ack,
    output logic [op_w-1:0] result,
    output fp_status_t      status
);

    logic            start;
    logic            done;
    fp_op_t          op_q;
    logic [op_w-1:0] x_q;
    logic [op_w-1:0] y_q;

    fp_operands_if #(.exp_w(exp_w), .frac_w(frac_w)) ops ();
    fp_raw_if      #(.exp_w(exp_w), .frac_w(frac_w)) add_raw ();
    fp_raw_if      #(.exp_w(exp_w), .frac_w(frac_w)) mul_raw ();

    fp_req_ctrl #(.exp_w(exp_w), .frac_w(frac_w)) u_ctrl
    (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .x     (x),
        .y     (y),
        .done  (done),
        .ack   (ack),
        .start (start),
        .op_q  (op_q),
        .x_q   (x_q),
        .y_q   (y_q)
    );

    fp_unpack #(.exp_w(exp_w), .frac_w(frac_w)) u_unpack
    (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .op_q  (op_q),
        .x_q   (x_q),
        .y_q   (y_q),
        .ops   (ops.source)
    );

    fp_add_core #(.exp_w(exp_w), .frac_w(frac_w)) u_add
    (
        .clk (clk),
        .rst (rst),
        .ops (ops.sink),
        .raw (add_raw.source)
    );

    fp_mul_core #(.exp_w(exp_w), .frac_w(frac_w)) u_mul
    (
        .clk (clk),
        .rst (rst),
        .ops (ops.sink),
        .raw (mul_raw.source)
    );

    fp_norm_pack #(.exp_w(exp_w), .frac_w(frac_w)) u_pack
    (
        .clk     (clk),
        .rst     (rst),
        .add_raw (add_raw.sink),
        .mul_raw (mul_raw.sink),
        .result  (result),
        .status  (status),
        .done    (done)
    );

endmodule

// File: logic/fp_unpack.sv
module fp_unpack import fp_format_pkg::*, fp_op_pkg::*;
#(
    parameter int exp_w  = sp_exp_w,
    parameter int frac_w = sp_frac_w,
    localparam int op_w  = 1 + exp_w + frac_w
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  fp_op_t          op_q,
    input  logic [op_w-1:0] x_q,
    input  logic [op_w-1:0] y_q,
    fp_operands_if.source   ops
);

    logic              x_sign;
    logic              y_sign;
    logic [exp_w-1:0]  x_exp;
    logic [exp_w-1:0]  y_exp;
    logic [frac_w:0]   x_sig;
    logic [frac_w:0]   y_sig;

    // field split, inputs are normal so the hidden one is always set
    assign x_sign = x_q[op_w-1];
    assign y_sign = y_q[op_w-1];
    assign x_exp  = x_q[op_w-2 -: exp_w];
    assign y_exp  = y_q[op_w-2 -: exp_w];
    assign x_sig  = {1'b1, x_q[frac_w-1:0]};
    assign y_sig  = {1'b1, y_q[frac_w-1:0]};

    always_ff @(posedge clk)
    begin
        if (rst)
            ops.valid <= 1'b0;
        else
            ops.valid <= start;
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            ops.sign_a <= x_sign;
            ops.sign_b <= y_sign;
            ops.exp_a  <= x_exp;
            ops.exp_b  <= y_exp;
            ops.sig_a  <= x_sig;
            ops.sig_b  <= y_sig;
            ops.op     <= op_q;
        end
    end

endmodule

// File: sim/fp_unit_tb.sv
module fp_unit_tb import fp_format_pkg::*, fp_op_pkg::*;
();

    localparam int op_w        = 1 + sp_exp_w + sp_frac_w;
    localparam int bias        = (1 << (sp_exp_w - 1)) - 1;
    localparam int max_exp     = (1 << sp_exp_w) - 2;  // largest finite code
    localparam int seed        = 41591;
    localparam int ack_latency = 4;
    localparam int ack_timeout = 20;
    localparam int op_count    = 200;
    localparam int range_count = 25;

    logic            clk = 1'b0;
    logic            rst;
    logic            req;
    fp_op_t          op;
    logic [op_w-1:0] x;
    logic [op_w-1:0] y;
    logic            ack;
    logic [op_w-1:0] result;
    fp_status_t      status;

    logic [31:0]     rand_state;
    logic            timed_out;
    int              result_errors;
    int              status_errors;
    int              latency_errors;
    int              handshake_errors;

    fp_unit #(.exp_w(sp_exp_w), .frac_w(sp_frac_w)) uut
    (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .x      (x),
        .y      (y),
        .ack    (ack),
        .result (result),
        .status (status)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // upper bits only since the low ones cycle fast
    function automatic int random_below(input int n);
        logic [31:0] v;
        v = next_random();
        return int'(v[31:8]) % n;
    endfunction

    function automatic int random_exp(input int lo, input int hi);
        return lo + random_below(hi - lo + 1);
    endfunction

    function automatic logic [sp_frac_w-1:0] random_frac();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] w;
        hi = next_random();
        lo = next_random();
        w  = {hi[31:16], lo[31:16]};
        return w[sp_frac_w-1:0];
    endfunction

    function automatic int clamp_exp(input int e);
        if (e < 1)
            return 1;
        else if (e > max_exp)
            return max_exp;
        return e;
    endfunction

    function automatic logic [op_w-1:0] make_operand(input logic sign, input int e,
                                                     input logic [sp_frac_w-1:0] f);
        return {sign, e[sp_exp_w-1:0], f};
    endfunction

    // exact integer arithmetic followed by truncation and range rules
    task automatic model_result(input fp_op_t o, input logic [op_w-1:0] a,
                                input logic [op_w-1:0] b, output logic [op_w-1:0] r,
                                output fp_status_t s);
        int          ea;
        int          eb;
        int          diff;
        int          base;
        int          lead;
        int          re;
        logic        a_big;
        logic        rs;
        logic        pass;
        logic [63:0] ma;
        logic [63:0] mb;
        logic [63:0] bm;
        logic [63:0] sm;
        logic [63:0] mag;
        logic [63:0] fr;
        ea    = int'(a[op_w-2 -: sp_exp_w]);
        eb    = int'(b[op_w-2 -: sp_exp_w]);
        ma    = 64'({1'b1, a[sp_frac_w-1:0]});  // hidden one back in
        mb    = 64'({1'b1, b[sp_frac_w-1:0]});
        a_big = (ea > eb) || ((ea == eb) && (ma >= mb));
        pass  = 1'b0;
        mag   = '0;
        s     = '0;
        if (o == op_mul)
        begin
            rs   = a[op_w-1] ^ b[op_w-1];
            mag  = ma * mb;
            base = ea + eb - bias - 2 * sp_frac_w;
        end
        else
        begin
            rs   = a_big ? a[op_w-1] : b[op_w-1];
            diff = a_big ? ea - eb : eb - ea;
            bm   = a_big ? ma : mb;
            sm   = a_big ? mb : ma;
            pass = diff > sp_frac_w + 1;  // larger operand comes back as is
            if (!pass)
            begin
                bm  = bm << (sp_frac_w + 1);
                sm  = sm << (sp_frac_w + 1 - diff);
                mag = (a[op_w-1] != b[op_w-1]) ? bm - sm : bm + sm;
            end
            base = (a_big ? ea : eb) - (2 * sp_frac_w + 1);
        end
        if (pass)
            r = a_big ? a : b;
        else if (mag == '0)
            r = '0;  // cancellation gives +0
        else
        begin
            lead = 63;
            while (!mag[lead])
                lead--;
            re = base + lead;
            fr = (lead >= sp_frac_w) ? (mag >> (lead - sp_frac_w)) : (mag << (sp_frac_w - lead));
            if (re > max_exp)
            begin
                r = {rs, max_exp[sp_exp_w-1:0], {sp_frac_w{1'b1}}};
                s.overflow = 1'b1;
            end
            else if (re < 1)
            begin
                r = {rs, {(op_w - 1){1'b0}}};
                s.underflow = 1'b1;
            end
            else
                r = {rs, re[sp_exp_w-1:0], fr[sp_frac_w-1:0]};
        end
    endtask

    task automatic check_result(input string name, input logic [op_w-1:0] expected,
                                input logic [op_w-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s result: expected %h, actual %h", name, expected, actual);
            result_errors++;
        end
    endtask

    task automatic check_status(input string name, input fp_status_t expected,
                                input fp_status_t actual);
        if (actual !== expected)
        begin
            $display("FAILED %s status: expected %b, actual %b", name, expected, actual);
            status_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("FAILED %s latency: expected %0d, actual %0d", name, expected, actual);
            latency_errors++;
        end
    endtask

    // group 0 add, 1 mul, 2 and 3 mul out of range, 4 and 5 add out of range
    task automatic pick_operands(input int group, output fp_op_t o,
                                 output logic [op_w-1:0] a, output logic [op_w-1:0] b);
        int                   kind;
        int                   ea;
        int                   eb;
        logic                 sa;
        logic                 sb;
        logic [sp_frac_w-1:0] fa;
        logic [sp_frac_w-1:0] fb;
        logic [op_w-1:0]      t;
        kind = random_below(4);
        sa   = (random_below(2) == 1);
        sb   = (random_below(2) == 1);
        fa   = random_frac();
        fb   = random_frac();
        ea   = random_exp(1, max_exp);
        eb   = random_exp(1, max_exp);
        o    = op_add;
        case (group)
            0:
            begin
                if (kind == 0)
                    eb = clamp_exp(ea + random_below(9) - 4);  // close exponents
                else if (kind == 1)
                begin
                    eb = ea;
                    sb = ~sa;
                    if (random_below(2) == 1)
                        fb = fa;  // exact cancellation
                    else
                        fb = fa ^ sp_frac_w'(random_below(256));
                end
                else if (kind == 2)
                begin
                    ea = random_exp(40, max_exp);
                    eb = ea - 20 - random_below(12);  // both sides of the far limit
                end
            end
            1:
            begin
                o  = op_mul;
                ea = random_exp(64, 190);
                eb = random_exp(64, 190);
            end
            2:
            begin
                o  = op_mul;
                ea = random_exp(200, max_exp);
                eb = random_exp(200, max_exp);
            end
            3:
            begin
                o  = op_mul;
                ea = random_exp(1, 60);
                eb = random_exp(1, 60);
            end
            4:
            begin
                ea = max_exp;  // carry out of the top code
                eb = max_exp;
                sb = sa;
            end
            default:
            begin
                ea = random_exp(1, 4);
                eb = ea;
                sb = ~sa;
                fb = fa ^ sp_frac_w'(1 + random_below(31));  // deep cancellation
            end
        endcase
        a = make_operand(sa, ea, fa);
        b = make_operand(sb, eb, fb);
        if (random_below(2) == 1)
        begin
            t = a;
            a = b;
            b = t;
        end
    endtask

    task automatic run_transaction(input string name, input fp_op_t o,
                                   input logic [op_w-1:0] a, input logic [op_w-1:0] b);
        logic [op_w-1:0] exp_result;
        fp_status_t      exp_status;
        int              cycles;
        int              extra;
        model_result(o, a, b, exp_result, exp_status);
        @(posedge clk);
        op  <= o;
        x   <= a;
        y   <= b;
        req <= 1'b1;
        @(posedge clk);  // req first sampled high here
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < ack_timeout)
        begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (!ack)
        begin
            $display("%s: ack did not rise within %0d cycles", name, ack_timeout);
            handshake_errors++;
            timed_out = 1'b1;
        end
        else
        begin
            check_latency(name, ack_latency, cycles);
            check_result(name, exp_result, result);
            check_status(name, exp_status, status);
            extra = random_below(4);
            repeat (extra)
            begin
                @(posedge clk);
                @(negedge clk);
                if (ack !== 1'b1)
                begin
                    $display("%s: ack fell while req was still high", name);
                    handshake_errors++;
                end
                check_result($sformatf("%s hold", name), exp_result, result);
                check_status($sformatf("%s hold", name), exp_status, status);
            end
            @(posedge clk);
            req <= 1'b0;
            cycles = 0;
            @(negedge clk);
            while (ack && cycles < ack_timeout)
            begin
                @(negedge clk);
                cycles++;
            end
            if (ack)
            begin
                $display("%s: ack stayed high after req dropped", name);
                handshake_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_group(input string label, input int group, input int count);
        fp_op_t          o;
        logic [op_w-1:0] a;
        logic [op_w-1:0] b;
        for (int i = 0; i < count && !timed_out; i++)
        begin
            pick_operands(group, o, a, b);
            run_transaction($sformatf("%s %0d", label, i), o, a, b);
        end
    endtask

    initial
    begin
        rand_state       = 32'(seed);
        timed_out        = 1'b0;
        result_errors    = 0;
        status_errors    = 0;
        latency_errors   = 0;
        handshake_errors = 0;
        rst = 1'b1;
        req = 1'b0;
        op  = op_add;
        x   = '0;
        y   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (ack !== 1'b0)
        begin
            $display("ack is not low after reset");
            handshake_errors++;
        end
        check_result("reset", '0, result);
        check_status("reset", '0, status);

        run_group("add", 0, op_count);
        run_group("mul", 1, op_count);
        run_group("mul overflow", 2, range_count);
        run_group("mul underflow", 3, range_count);
        run_group("add overflow", 4, range_count);
        run_group("add underflow", 5, range_count);

        $display("errors: result %0d, status %0d, latency %0d, handshake %0d",
                 result_errors, status_errors, latency_errors, handshake_errors);
        if (result_errors + status_errors + latency_errors + handshake_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
